/* rtl/pf_blend_pkg.sv */
/*
 * shared types and constants of the two-playfield colour stage
 * palette words are 16-bit XRGB, red/green/blue as 4-bit nibbles
 * the top nibble means different things in palette A and palette B
 * the AXI address map assumes 32-bit aligned accesses
 */
package pf_blend_pkg;

    // palette geometry
    localparam int PAL_INDEX_W = 8;
    localparam int PAL_DEPTH   = 256;

    // host register map, byte addresses
    localparam int AXIL_ADDR_W = 12;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_CTRL       = 12'h000;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_PAL_A_BASE = 12'h400;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_PAL_B_BASE = 12'h800;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // B alpha field when A mode bit is 0
    localparam logic [1:0] ALPHA_A100 = 2'b00;
    localparam logic [1:0] ALPHA_A75  = 2'b01;
    localparam logic [1:0] ALPHA_A50  = 2'b10;
    localparam logic [1:0] ALPHA_B100 = 2'b11;

    // B alpha field when A mode bit is 1
    localparam logic [1:0] OP_ADD    = 2'b00;
    localparam logic [1:0] OP_SUB    = 2'b01;
    localparam logic [1:0] OP_DELTA  = 2'b10;
    localparam logic [1:0] OP_DELTA2 = 2'b11;

    // one palette word, read as an A colour or as a B colour
    typedef union packed {
        struct packed {
            logic       mode;
            logic [2:0] pad;
            logic [3:0] red;
            logic [3:0] green;
            logic [3:0] blue;
        } a_view;
        struct packed {
            logic [1:0] alpha;
            logic [1:0] pad;
            logic [3:0] red;
            logic [3:0] green;
            logic [3:0] blue;
        } b_view;
    } xrgb_word_u;

endpackage

/* rtl/axil_palette_regs.sv */
/*
 * AXI4-Lite slave for the palettes and the control register
 * one outstanding write and one outstanding read at a time
 * palettes are write-only, reading them gives zero with SLVERR
 * a palette write needs wstrb[1:0] both set, other strobes ignored
 */
module axil_palette_regs import pf_blend_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic [AXIL_ADDR_W-1:0] s_axil_awaddr_i,
    input  logic                   s_axil_awvalid_i,
    output logic                   s_axil_awready_o,
    input  logic [31:0]            s_axil_wdata_i,
    input  logic [3:0]             s_axil_wstrb_i,
    input  logic                   s_axil_wvalid_i,
    output logic                   s_axil_wready_o,
    output logic [1:0]             s_axil_bresp_o,
    output logic                   s_axil_bvalid_o,
    input  logic                   s_axil_bready_i,
    input  logic [AXIL_ADDR_W-1:0] s_axil_araddr_i,
    input  logic                   s_axil_arvalid_i,
    output logic                   s_axil_arready_o,
    output logic [31:0]            s_axil_rdata_o,
    output logic [1:0]             s_axil_rresp_o,
    output logic                   s_axil_rvalid_o,
    input  logic                   s_axil_rready_i,
    output logic                   pal_we_o,
    output logic                   pal_sel_b_o,
    output logic [PAL_INDEX_W-1:0] pal_addr_o,
    output logic [15:0]            pal_wdata_o,
    output logic                   pb_enable_o
);

    logic aw_ready;
    logic b_valid;
    logic ar_ready;
    logic r_valid;
    logic wr_go;
    logic rd_go;
    logic wr_is_ctrl;
    logic wr_is_pal_a;
    logic wr_is_pal_b;
    logic rd_is_ctrl;

    // handshake completes on the cycle ready is up
    assign wr_go = aw_ready & s_axil_awvalid_i & s_axil_wvalid_i;
    assign rd_go = ar_ready & s_axil_arvalid_i;

    // control register is a single word
    assign wr_is_ctrl = (s_axil_awaddr_i[AXIL_ADDR_W-1:2] == ADDR_CTRL[AXIL_ADDR_W-1:2]);
    assign rd_is_ctrl = (s_axil_araddr_i[AXIL_ADDR_W-1:2] == ADDR_CTRL[AXIL_ADDR_W-1:2]);

    // each palette spans 1 KiB, one word per entry
    assign wr_is_pal_a = (s_axil_awaddr_i[AXIL_ADDR_W-1:PAL_INDEX_W+2]
                          == ADDR_PAL_A_BASE[AXIL_ADDR_W-1:PAL_INDEX_W+2]);
    assign wr_is_pal_b = (s_axil_awaddr_i[AXIL_ADDR_W-1:PAL_INDEX_W+2]
                          == ADDR_PAL_B_BASE[AXIL_ADDR_W-1:PAL_INDEX_W+2]);

    // write channel control
    always_ff @(posedge clk) begin
        if (reset_i) begin
            aw_ready    <= 1'b0;
            b_valid     <= 1'b0;
            pal_we_o    <= 1'b0;
            pb_enable_o <= 1'b0;
        end else begin
            // address and data accepted together, held off while B is pending
            aw_ready <= s_axil_awvalid_i & s_axil_wvalid_i & ~aw_ready & ~b_valid;
            // one-cycle RAM strobe, only for full low halfword
            pal_we_o <= wr_go & (wr_is_pal_a | wr_is_pal_b) & (&s_axil_wstrb_i[1:0]);
            if (wr_go) begin
                b_valid <= 1'b1;
            end else if (s_axil_bready_i) begin
                b_valid <= 1'b0;
            end
            if (wr_go && wr_is_ctrl && s_axil_wstrb_i[0]) begin
                pb_enable_o <= s_axil_wdata_i[0];
            end
        end
    end

    // write payload, captured at the handshake
    always_ff @(posedge clk) begin
        if (wr_go) begin
            s_axil_bresp_o <= (wr_is_ctrl | wr_is_pal_a | wr_is_pal_b) ? RESP_OKAY
                                                                       : RESP_SLVERR;
            pal_sel_b_o    <= wr_is_pal_b;
            pal_addr_o     <= s_axil_awaddr_i[PAL_INDEX_W+1:2];
            pal_wdata_o    <= s_axil_wdata_i[15:0];
        end
    end

    // read channel control
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
        end else begin
            ar_ready <= s_axil_arvalid_i & ~ar_ready & ~r_valid;
            if (rd_go) begin
                r_valid <= 1'b1;
            end else if (s_axil_rready_i) begin
                r_valid <= 1'b0;
            end
        end
    end

    // read data, only the control word is readable
    always_ff @(posedge clk) begin
        if (rd_go) begin
            if (rd_is_ctrl) begin
                s_axil_rdata_o <= {31'b0, pb_enable_o};
                s_axil_rresp_o <= RESP_OKAY;
            end else begin
                s_axil_rdata_o <= 32'b0;
                s_axil_rresp_o <= RESP_SLVERR;
            end
        end
    end

    assign s_axil_awready_o = aw_ready;
    assign s_axil_wready_o  = aw_ready;
    assign s_axil_bvalid_o  = b_valid;
    assign s_axil_arready_o = ar_ready;
    assign s_axil_rvalid_o  = r_valid;

endmodule

/* rtl/palette_lut.sv */
/*
 * two 256 x 16 palette RAMs, one per playfield
 * reads every cycle, result registered one cycle after the index
 * contents are not reset, the host must load both palettes
 * a write and a read of the same entry return the old word
 */
module palette_lut import pf_blend_pkg::*; (
    input  logic                   clk,
    input  logic                   pal_we_i,
    input  logic                   pal_sel_b_i,
    input  logic [PAL_INDEX_W-1:0] pal_addr_i,
    input  logic [15:0]            pal_wdata_i,
    input  logic [PAL_INDEX_W-1:0] pf_a_index_i,
    input  logic [PAL_INDEX_W-1:0] pf_b_index_i,
    output logic [15:0]            color_a_o,
    output logic [15:0]            color_b_o
);

    // bank 0 is playfield A, bank 1 is playfield B
    logic [PAL_INDEX_W-1:0] rd_index [2];
    logic [15:0]            rd_color [2];

    assign rd_index[0] = pf_a_index_i;
    assign rd_index[1] = pf_b_index_i;

    for (genvar bank = 0; bank < 2; bank++) begin : g_bank
        logic [15:0] mem [PAL_DEPTH];
        logic        bank_we;

        // shared write port, steered by the palette select
        assign bank_we = pal_we_i & (pal_sel_b_i == bank[0]);

        always_ff @(posedge clk) begin
            if (bank_we) begin
                mem[pal_addr_i] <= pal_wdata_i;
            end
            // block RAM style registered read
            rd_color[bank] <= mem[rd_index[bank]];
        end
    end

    assign color_a_o = rd_color[0];
    assign color_b_o = rd_color[1];

endmodule

/* rtl/video_blend.sv */
/*
 * blends the looked-up A and B colours into 4-bit RGB
 * sync and enable get one register to match the palette read,
 * then share the output register with RGB, two cycles in all
 * pb_enable low passes A's colour through untouched
 */
module video_blend import pf_blend_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       pb_enable_i,
    input  logic       vsync_i,
    input  logic       hsync_i,
    input  logic       dv_de_i,
    input  xrgb_word_u color_a_i,
    input  xrgb_word_u color_b_i,
    output logic [3:0] red_o,
    output logic [3:0] green_o,
    output logic [3:0] blue_o,
    output logic       hsync_o,
    output logic       vsync_o,
    output logic       dv_de_o
);

    // one channel of the blend, mode from A, op or alpha from B
    function automatic logic [3:0] blend_chan(
        input logic [3:0] a,
        input logic [3:0] b,
        input logic       mode,
        input logic [1:0] sel
    );
        logic [4:0] sum;
        logic [4:0] diff;
        logic [5:0] mix75;
        logic [5:0] sum_x2;
        logic [3:0] res;
        sum    = {1'b0, a} + {1'b0, b};
        diff   = {1'b0, a} - {1'b0, b};
        // a/2 + a/4 + b/4, done as 2a + a + b then shifted
        mix75  = {2'b00, a} + {1'b0, a, 1'b0} + {2'b00, b};
        // b doubled, anything past 15 is a carry out of the nibble
        sum_x2 = {2'b00, a} + {1'b0, b, 1'b0};
        if (!mode) begin
            case (sel)
                ALPHA_A100: res = a;
                ALPHA_A75:  res = mix75[5:2];
                ALPHA_A50:  res = sum[4:1];
                default:    res = b;
            endcase
        end else begin
            case (sel)
                OP_ADD:   res = sum[4] ? 4'hF : sum[3:0];
                // borrow shows up in bit 4
                OP_SUB:   res = diff[4] ? 4'h0 : diff[3:0];
                // on carry, B's top bit picks the clamp direction
                OP_DELTA: res = sum[4] ? (b[3] ? 4'h0 : 4'hF) : sum[3:0];
                default:  res = (sum_x2 > 6'd15) ? (b[3] ? 4'h0 : 4'hF) : sum_x2[3:0];
            endcase
        end
        return res;
    endfunction

    // sync and enable aligned to the palette output
    logic       hsync_1;
    logic       vsync_1;
    logic       dv_de_1;
    logic [3:0] blend_r;
    logic [3:0] blend_g;
    logic [3:0] blend_b;

    always_comb begin
        blend_r = blend_chan(color_a_i.a_view.red, color_b_i.b_view.red,
                             color_a_i.a_view.mode, color_b_i.b_view.alpha);
        blend_g = blend_chan(color_a_i.a_view.green, color_b_i.b_view.green,
                             color_a_i.a_view.mode, color_b_i.b_view.alpha);
        blend_b = blend_chan(color_a_i.a_view.blue, color_b_i.b_view.blue,
                             color_a_i.a_view.mode, color_b_i.b_view.alpha);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hsync_1 <= 1'b0;
            vsync_1 <= 1'b0;
            dv_de_1 <= 1'b0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            dv_de_o <= 1'b0;
            red_o   <= 4'h0;
            green_o <= 4'h0;
            blue_o  <= 4'h0;
        end else begin
            // first stage, matches the RAM read
            hsync_1 <= hsync_i;
            vsync_1 <= vsync_i;
            dv_de_1 <= dv_de_i;
            // second stage, output register
            hsync_o <= hsync_1;
            vsync_o <= vsync_1;
            dv_de_o <= dv_de_1;
            if (!dv_de_1) begin
                // blanking
                red_o   <= 4'h0;
                green_o <= 4'h0;
                blue_o  <= 4'h0;
            end else if (!pb_enable_i) begin
                red_o   <= color_a_i.a_view.red;
                green_o <= color_a_i.a_view.green;
                blue_o  <= color_a_i.a_view.blue;
            end else begin
                red_o   <= blend_r;
                green_o <= blend_g;
                blue_o  <= blend_b;
            end
        end
    end

endmodule

/* rtl/pf_blend_top.sv */
/*
 * colour stage top, host port plus pixel pipeline
 * pixel inputs appear on the RGB and sync outputs two clocks later
 * no stall, a new pixel may arrive every cycle
 */
module pf_blend_top import pf_blend_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_i,
    // host register port
    input  logic [AXIL_ADDR_W-1:0] s_axil_awaddr_i,
    input  logic                   s_axil_awvalid_i,
    output logic                   s_axil_awready_o,
    input  logic [31:0]            s_axil_wdata_i,
    input  logic [3:0]             s_axil_wstrb_i,
    input  logic                   s_axil_wvalid_i,
    output logic                   s_axil_wready_o,
    output logic [1:0]             s_axil_bresp_o,
    output logic                   s_axil_bvalid_o,
    input  logic                   s_axil_bready_i,
    input  logic [AXIL_ADDR_W-1:0] s_axil_araddr_i,
    input  logic                   s_axil_arvalid_i,
    output logic                   s_axil_arready_o,
    output logic [31:0]            s_axil_rdata_o,
    output logic [1:0]             s_axil_rresp_o,
    output logic                   s_axil_rvalid_o,
    input  logic                   s_axil_rready_i,
    // pixels from the playfield renderers
    input  logic [PAL_INDEX_W-1:0] pf_a_index_i,
    input  logic [PAL_INDEX_W-1:0] pf_b_index_i,
    input  logic                   hsync_i,
    input  logic                   vsync_i,
    input  logic                   dv_de_i,
    // video out
    output logic [3:0]             red_o,
    output logic [3:0]             green_o,
    output logic [3:0]             blue_o,
    output logic                   hsync_o,
    output logic                   vsync_o,
    output logic                   dv_de_o
);

    // palette write port
    logic                   pal_we;
    logic                   pal_sel_b;
    logic [PAL_INDEX_W-1:0] pal_addr;
    logic [15:0]            pal_wdata;
    logic                   pb_enable;
    // looked-up colours
    logic [15:0]            color_a;
    logic [15:0]            color_b;

    axil_palette_regs u_regs (
        .clk              (clk),
        .reset_i          (reset_i),
        .s_axil_awaddr_i  (s_axil_awaddr_i),
        .s_axil_awvalid_i (s_axil_awvalid_i),
        .s_axil_awready_o (s_axil_awready_o),
        .s_axil_wdata_i   (s_axil_wdata_i),
        .s_axil_wstrb_i   (s_axil_wstrb_i),
        .s_axil_wvalid_i  (s_axil_wvalid_i),
        .s_axil_wready_o  (s_axil_wready_o),
        .s_axil_bresp_o   (s_axil_bresp_o),
        .s_axil_bvalid_o  (s_axil_bvalid_o),
        .s_axil_bready_i  (s_axil_bready_i),
        .s_axil_araddr_i  (s_axil_araddr_i),
        .s_axil_arvalid_i (s_axil_arvalid_i),
        .s_axil_arready_o (s_axil_arready_o),
        .s_axil_rdata_o   (s_axil_rdata_o),
        .s_axil_rresp_o   (s_axil_rresp_o),
        .s_axil_rvalid_o  (s_axil_rvalid_o),
        .s_axil_rready_i  (s_axil_rready_i),
        .pal_we_o         (pal_we),
        .pal_sel_b_o      (pal_sel_b),
        .pal_addr_o       (pal_addr),
        .pal_wdata_o      (pal_wdata),
        .pb_enable_o      (pb_enable)
    );

    palette_lut u_lut (
        .clk          (clk),
        .pal_we_i     (pal_we),
        .pal_sel_b_i  (pal_sel_b),
        .pal_addr_i   (pal_addr),
        .pal_wdata_i  (pal_wdata),
        .pf_a_index_i (pf_a_index_i),
        .pf_b_index_i (pf_b_index_i),
        .color_a_o    (color_a),
        .color_b_o    (color_b)
    );

    video_blend u_blend (
        .clk         (clk),
        .reset_i     (reset_i),
        .pb_enable_i (pb_enable),
        .vsync_i     (vsync_i),
        .hsync_i     (hsync_i),
        .dv_de_i     (dv_de_i),
        .color_a_i   (color_a),
        .color_b_i   (color_b),
        .red_o       (red_o),
        .green_o     (green_o),
        .blue_o      (blue_o),
        .hsync_o     (hsync_o),
        .vsync_o     (vsync_o),
        .dv_de_o     (dv_de_o)
    );

endmodule

/* test/tb_pf_blend_top.sv */
/*
 * testbench for the two-playfield colour stage
 * loads both palettes over AXI4-Lite, then plays a pixel table twice,
 * first with playfield B off and then with blending on
 * expected colours come from a model of the blend rules on a local palette copy
 */
module tb_pf_blend_top import pf_blend_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 100;
    localparam int N_ROWS     = 28;
    // reset read, both palettes, two error cases, back-pressure pair, enable write and read
    localparam int AXI_OPS         = 2 * PAL_DEPTH + 7;
    localparam int WATCHDOG_CYCLES = (2 * N_ROWS + AXI_OPS) * 20;

    // {A index, B index, hsync, vsync, dv_de}
    localparam logic [18:0] PIX_TABLE [N_ROWS] = '{
        {8'h70, 8'hE0, 3'b001}, {8'h70, 8'hE1, 3'b001}, {8'h70, 8'hE2, 3'b101},
        {8'h70, 8'hE3, 3'b001}, {8'h71, 8'hF0, 3'b001}, {8'h71, 8'hF1, 3'b011},
        {8'h71, 8'hF2, 3'b001}, {8'h71, 8'hF3, 3'b001}, {8'hF0, 8'hF0, 3'b001},
        {8'hF0, 8'hF1, 3'b101}, {8'hF0, 8'hF2, 3'b001}, {8'hF0, 8'hF3, 3'b111},
        {8'hF1, 8'hF0, 3'b001}, {8'hF1, 8'hF1, 3'b001}, {8'hF1, 8'hF2, 3'b001},
        {8'hF1, 8'hF3, 3'b011}, {8'hF0, 8'hD0, 3'b001}, {8'hF0, 8'hD1, 3'b001},
        {8'hF0, 8'hD2, 3'b101}, {8'hF0, 8'hD3, 3'b001}, {8'hF0, 8'hF0, 3'b100},
        {8'h70, 8'hE1, 3'b010}, {8'h12, 8'h34, 3'b000}, {8'h12, 8'h34, 3'b001},
        {8'h9A, 8'h5B, 3'b101}, {8'hC0, 8'hC0, 3'b001}, {8'hC0, 8'hC1, 3'b011},
        {8'hFF, 8'h07, 3'b001}
    };

    logic        clk;
    logic        reset_i;
    logic [11:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [11:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic [7:0]  pf_a_index;
    logic [7:0]  pf_b_index;
    logic        hsync;
    logic        vsync;
    logic        dv_de;
    logic [3:0]  red;
    logic [3:0]  green;
    logic [3:0]  blue;
    logic        hsync_out;
    logic        vsync_out;
    logic        dv_de_out;

    // local copy of what the host has written
    xrgb_word_u  pal_a [PAL_DEPTH];
    xrgb_word_u  pal_b [PAL_DEPTH];
    logic [31:0] rng_state = 32'h3d01;
    int          n_checks  = 0;
    int          n_errors  = 0;

    pf_blend_top dut0 (
        .clk              (clk),
        .reset_i          (reset_i),
        .s_axil_awaddr_i  (awaddr),
        .s_axil_awvalid_i (awvalid),
        .s_axil_awready_o (awready),
        .s_axil_wdata_i   (wdata),
        .s_axil_wstrb_i   (wstrb),
        .s_axil_wvalid_i  (wvalid),
        .s_axil_wready_o  (wready),
        .s_axil_bresp_o   (bresp),
        .s_axil_bvalid_o  (bvalid),
        .s_axil_bready_i  (bready),
        .s_axil_araddr_i  (araddr),
        .s_axil_arvalid_i (arvalid),
        .s_axil_arready_o (arready),
        .s_axil_rdata_o   (rdata),
        .s_axil_rresp_o   (rresp),
        .s_axil_rvalid_o  (rvalid),
        .s_axil_rready_i  (rready),
        .pf_a_index_i     (pf_a_index),
        .pf_b_index_i     (pf_b_index),
        .hsync_i          (hsync),
        .vsync_i          (vsync),
        .dv_de_i          (dv_de),
        .red_o            (red),
        .green_o          (green),
        .blue_o           (blue),
        .hsync_o          (hsync_out),
        .vsync_o          (vsync_out),
        .dv_de_o          (dv_de_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // bound on run time, scaled by the amount of traffic
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, a handshake never completed");
        $display("Regression failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // one channel, straight from the blend tables
    function automatic logic [3:0] chan_ref(input int a, input int b,
                                            input logic mode, input logic [1:0] sel);
        int r;
        if (!mode) begin
            case (sel)
                ALPHA_A100: r = a;
                ALPHA_A75:  r = (3 * a + b) / 4;
                ALPHA_A50:  r = (a + b) / 2;
                default:    r = b;
            endcase
        end else begin
            case (sel)
                OP_ADD:   r = (a + b > 15) ? 15 : a + b;
                OP_SUB:   r = (a - b < 0) ? 0 : a - b;
                OP_DELTA: r = a + b;
                default:  r = a + 2 * b;
            endcase
            // delta modes clamp by the sign of B
            if ((sel == OP_DELTA || sel == OP_DELTA2) && r > 15) begin
                r = (b >= 8) ? 0 : 15;
            end
        end
        return r[3:0];
    endfunction

    // expected {r, g, b} for one displayed pixel
    function automatic logic [11:0] blend_ref(input logic [7:0] ai, input logic [7:0] bi,
                                              input logic pb);
        xrgb_word_u  wa;
        xrgb_word_u  wb;
        logic [11:0] ra;
        logic [11:0] rb;
        logic [11:0] res;
        wa = pal_a[ai];
        wb = pal_b[bi];
        ra = {wa.a_view.red, wa.a_view.green, wa.a_view.blue};
        rb = {wb.b_view.red, wb.b_view.green, wb.b_view.blue};
        if (!pb) begin
            return ra;
        end
        for (int ch = 0; ch < 3; ch++) begin
            res[ch*4 +: 4] = chan_ref(int'(ra[ch*4 +: 4]), int'(rb[ch*4 +: 4]),
                                      wa.a_view.mode, wb.b_view.alpha);
        end
        return res;
    endfunction

    task automatic check_hex(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            n_errors++;
        end
    endtask

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        // address and data channels are taken together
        check_hex("wready", 32'(wready), 32'h1);
        // accepted on the coming rising edge
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        resp = bresp;
    endtask

    task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
    endtask

    // plays the table back to back, outputs checked two falling edges later
    task automatic run_pixels(input logic pb);
        logic [11:0] exp_rgb [N_ROWS];
        logic [18:0] row;
        for (int j = 0; j < N_ROWS + 2; j++) begin
            @(negedge clk);
            if (j >= 2) begin
                row = PIX_TABLE[j-2];
                check_hex("rgb", 32'({red, green, blue}), 32'(exp_rgb[j-2]));
                check_hex("hsync_o", 32'(hsync_out), 32'(row[2]));
                check_hex("vsync_o", 32'(vsync_out), 32'(row[1]));
                check_hex("dv_de_o", 32'(dv_de_out), 32'(row[0]));
            end
            if (j < N_ROWS) begin
                row        = PIX_TABLE[j];
                pf_a_index = row[18:11];
                pf_b_index = row[10:3];
                hsync      = row[2];
                vsync      = row[1];
                dv_de      = row[0];
                exp_rgb[j] = row[0] ? blend_ref(row[18:11], row[10:3], pb) : 12'h000;
            end else begin
                pf_a_index = 8'h00;
                pf_b_index = 8'h00;
                hsync      = 1'b0;
                vsync      = 1'b0;
                dv_de      = 1'b0;
            end
        end
    endtask

    initial begin
        logic [1:0]  resp;
        logic [31:0] data;
        logic [7:0]  idx;
        reset_i    = 1'b1;
        awaddr     = 12'h000;
        awvalid    = 1'b0;
        wdata      = 32'h0;
        wstrb      = 4'h0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = 12'h000;
        arvalid    = 1'b0;
        rready     = 1'b0;
        pf_a_index = 8'h00;
        pf_b_index = 8'h00;
        hsync      = 1'b0;
        vsync      = 1'b0;
        dv_de      = 1'b0;
        repeat (5) @(negedge clk);
        reset_i = 1'b0;

        // state right after reset
        check_hex("rgb", 32'({red, green, blue}), 32'h0);
        check_hex("hsync_o", 32'(hsync_out), 32'h0);
        check_hex("vsync_o", 32'(vsync_out), 32'h0);
        check_hex("dv_de_o", 32'(dv_de_out), 32'h0);
        check_hex("bvalid", 32'(bvalid), 32'h0);
        check_hex("rvalid", 32'(rvalid), 32'h0);
        axi_read(ADDR_CTRL, data, resp);
        check_hex("ctrl rdata", data, 32'h0);
        check_hex("ctrl rresp", 32'(resp), 32'(RESP_OKAY));

        // random colours, A mode from index bit 7, B alpha from the low index bits
        for (int i = 0; i < PAL_DEPTH; i++) begin
            idx       = 8'(i);
            rng_state = xorshift32(rng_state);
            pal_a[idx] = {idx[7], 3'b000, rng_state[11:0]};
            pal_b[idx] = {idx[1:0], 2'b00, rng_state[27:16]};
        end
        // saturation and truncation corners
        pal_a[8'h70] = 16'h0FFF;
        pal_a[8'h71] = 16'h0000;
        pal_a[8'hF0] = 16'h8FFF;
        pal_a[8'hF1] = 16'h8000;
        for (int k = 0; k < 4; k++) begin
            pal_b[8'hE0 + 8'(k)] = {2'(k), 14'h0000};
            pal_b[8'hF0 + 8'(k)] = {2'(k), 14'h0FFF};
            pal_b[8'hD0 + 8'(k)] = {2'(k), 14'h0777};
        end
        for (int i = 0; i < PAL_DEPTH; i++) begin
            idx = 8'(i);
            axi_write(ADDR_PAL_A_BASE + {2'b00, idx, 2'b00}, {16'h0, pal_a[idx]}, resp);
            check_hex("pal A bresp", 32'(resp), 32'(RESP_OKAY));
            axi_write(ADDR_PAL_B_BASE + {2'b00, idx, 2'b00}, {16'h0, pal_b[idx]}, resp);
            check_hex("pal B bresp", 32'(resp), 32'(RESP_OKAY));
        end

        // B disabled, every shown pixel is A's colour
        run_pixels(1'b0);

        // unmapped write, index C0 rows later show both palettes untouched
        axi_write(12'h300, 32'h0000_ABCD, resp);
        check_hex("unmapped bresp", 32'(resp), 32'(RESP_SLVERR));
        axi_read(ADDR_PAL_A_BASE + 12'h004, data, resp);
        check_hex("palette rdata", data, 32'h0);
        check_hex("palette rresp", 32'(resp), 32'(RESP_SLVERR));

        // response held off, a second write waits behind it
        @(negedge clk);
        awaddr  = ADDR_CTRL;
        wdata   = 32'h0;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0;
        @(negedge clk);
        while (!awready) @(negedge clk);
        @(negedge clk);
        rng_state    = xorshift32(rng_state);
        pal_a[8'hFF] = {1'b1, 3'b000, rng_state[11:0]};
        awaddr       = ADDR_PAL_A_BASE + 12'h3FC;
        wdata        = {16'h0, pal_a[8'hFF]};
        for (int k = 0; k < 4; k++) begin
            n_checks++;
            if (!bvalid) begin
                $display("BVALID dropped while BREADY was held low");
                n_errors++;
            end
            n_checks++;
            if (awready || wready) begin
                $display("second write accepted while a response was still pending");
                n_errors++;
            end
            @(negedge clk);
        end
        check_hex("held bresp", 32'(bresp), 32'(RESP_OKAY));
        bready = 1'b1;
        while (!awready) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        check_hex("queued bresp", 32'(bresp), 32'(RESP_OKAY));

        // turn on playfield B and play the table again
        axi_write(ADDR_CTRL, 32'h1, resp);
        check_hex("ctrl bresp", 32'(resp), 32'(RESP_OKAY));
        axi_read(ADDR_CTRL, data, resp);
        check_hex("ctrl rdata", data, 32'h1);
        check_hex("ctrl rresp", 32'(resp), 32'(RESP_OKAY));
        run_pixels(1'b1);

        $display("checks run %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* pf_blend.f */
rtl/pf_blend_pkg.sv
rtl/axil_palette_regs.sv
rtl/palette_lut.sv
rtl/video_blend.sv
rtl/pf_blend_top.sv
test/tb_pf_blend_top.sv

/* run_sim.sh */
#!/bin/sh
# builds the colour stage testbench with Verilator and runs it
# exit status is 0 only if the build, the run and the log all look clean

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_pf_blend_top -Mdir "$OBJ" -o tb_sim -f pf_blend.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    echo "simulation log reports a failure"
    exit 1
fi

echo "simulation log is clean"
exit 0
